/* drop_counter_bank.sv */
`timescale 1ns/1ps

module drop_counter_bank
(
    input  logic                      axis_aclk,
    input  logic                      axis_resetn,
    input  enq_cfg_pkg::drop_event_t  drop_ev,
    input  enq_cfg_pkg::cpu_req_t     cpu_req,
    output enq_cfg_pkg::cpu_resp_t    cpu_resp
);

    import enq_cfg_pkg::*;

    // cnt[src][dst]
    logic [CNT_WIDTH-1:0]        cnt [QUEUE_NUM][QUEUE_NUM];

    logic [CPU_ADDR_WIDTH/2-1:0] rd_src;
    logic [CPU_ADDR_WIDTH/2-1:0] rd_dst;
    port_idx_t                   rd_dst_idx;
    logic [CNT_WIDTH-1:0]        rd_data;

    ////////////////////////////////////////////////////////////
    // drop counting
    ////////////////////////////////////////////////////////////

    // one increment per destination of the dropped packet, wraps
    always_ff @(posedge axis_aclk)
    begin
        if (!axis_resetn)
        begin
            for (int s = 0; s < QUEUE_NUM; s++)
            begin
                for (int d = 0; d < QUEUE_NUM; d++)
                begin
                    cnt[s][d] <= '0;
                end
            end
        end
        else if (drop_ev.valid && (drop_ev.src_idx < QUEUE_NUM))
        begin
            for (int d = 0; d < QUEUE_NUM; d++)
            begin
                if (drop_ev.dst_vec[d])
                begin
                    cnt[drop_ev.src_idx][d] <= cnt[drop_ev.src_idx][d] + 1'b1;
                end
            end
        end
    end

    ////////////////////////////////////////////////////////////
    // cpu read port
    ////////////////////////////////////////////////////////////

    assign rd_src = cpu_req.addr[CPU_ADDR_WIDTH-1 -: CPU_ADDR_WIDTH/2];
    assign rd_dst = cpu_req.addr[CPU_ADDR_WIDTH/2-1:0];

    // out of range destination folds onto the cpu column
    assign rd_dst_idx = (rd_dst >= QUEUE_NUM) ? port_idx_t'(QUEUE_NUM - 1)
                                              : port_idx_t'(rd_dst);

    always_comb
    begin
        if (rd_src < QUEUE_NUM)
            rd_data = cnt[port_idx_t'(rd_src)][rd_dst_idx];
        else
            rd_data = '0;
    end

    always_ff @(posedge axis_aclk)
    begin
        if (!axis_resetn)
        begin
            cpu_resp <= '0;
        end
        else
        begin
            cpu_resp.valid <= cpu_req.valid;
            cpu_resp.data  <= rd_data;
        end
    end

endmodule

/* enq_cfg_pkg.sv */
package enq_cfg_pkg;

    // five output queues, NF0..NF3 then the CPU port
    localparam int QUEUE_NUM      = 5;
    localparam int CNT_WIDTH      = 32;
    // upper nibble source, lower nibble destination
    localparam int CPU_ADDR_WIDTH = 8;

    typedef logic [QUEUE_NUM-1:0] port_vec_t;
    typedef logic [2:0]           port_idx_t;

    typedef struct packed {
        port_vec_t buffer_almost_full;
        port_vec_t pifo_full;
    } queue_status_t;

    typedef struct packed {
        port_vec_t pifo_in_en;
        port_vec_t buffer_wr_en;
    } enq_ctl_t;

    typedef struct packed {
        logic      valid;
        port_idx_t src_idx;
        port_vec_t dst_vec;
    } drop_event_t;

    typedef struct packed {
        logic [CPU_ADDR_WIDTH-1:0] addr;
        logic                      valid;
    } cpu_req_t;

    typedef struct packed {
        logic [CNT_WIDTH-1:0] data;
        logic                 valid;
    } cpu_resp_t;

endpackage

/* enqueue_agent.f */
enq_cfg_pkg.sv
sume_meta_pkg.sv
meta_decoder.sv
enqueue_fsm.sv
drop_counter_bank.sv
enqueue_agent.sv
enqueue_agent_asserts.sv
enqueue_agent_tb.sv

/* enqueue_agent.sv */
`timescale 1ns/1ps

module enqueue_agent
(
    input  logic                        axis_aclk,
    input  logic                        axis_resetn,

    // pipeline stream
    input  logic                        s_axis_tvalid,
    output logic                        s_axis_tready,
    input  sume_meta_pkg::sume_meta_t   s_axis_tuser,
    input  logic                        s_axis_tlast,
    input  logic                        s_axis_tpifo_valid,

    // per port fill status and enables
    input  enq_cfg_pkg::queue_status_t  queue_status,
    output enq_cfg_pkg::enq_ctl_t       ctl,

    // counter read port
    input  enq_cfg_pkg::cpu_req_t       cpu_req,
    output enq_cfg_pkg::cpu_resp_t      cpu_resp
);

    import enq_cfg_pkg::*;

    port_vec_t   dst_vec;
    port_vec_t   eligible_vec;
    port_idx_t   src_idx;
    logic        reject;
    drop_event_t drop_ev;

    meta_decoder u_meta_decoder
    (
        .meta         (s_axis_tuser),
        .pifo_valid   (s_axis_tpifo_valid),
        .status       (queue_status),
        .dst_vec      (dst_vec),
        .src_idx      (src_idx),
        .eligible_vec (eligible_vec),
        .reject       (reject)
    );

    enqueue_fsm u_enqueue_fsm
    (
        .axis_aclk    (axis_aclk),
        .axis_resetn  (axis_resetn),
        .tvalid       (s_axis_tvalid),
        .tlast        (s_axis_tlast),
        .tready       (s_axis_tready),
        .dst_vec      (dst_vec),
        .eligible_vec (eligible_vec),
        .src_idx      (src_idx),
        .reject       (reject),
        .ctl          (ctl),
        .drop_ev      (drop_ev)
    );

    drop_counter_bank u_drop_counter_bank
    (
        .axis_aclk    (axis_aclk),
        .axis_resetn  (axis_resetn),
        .drop_ev      (drop_ev),
        .cpu_req      (cpu_req),
        .cpu_resp     (cpu_resp)
    );

endmodule

/* enqueue_agent_asserts.sv */
`timescale 1ns/1ps

module enqueue_agent_asserts
(
    input logic                    axis_aclk,
    input logic                    axis_resetn,
    input logic                    s_axis_tready,
    input enq_cfg_pkg::enq_ctl_t   ctl,
    input enq_cfg_pkg::cpu_req_t   cpu_req,
    input enq_cfg_pkg::cpu_resp_t  cpu_resp
);

    // pifo insert only where the buffer is written
    pifo_in_wr: assert property (@(posedge axis_aclk) disable iff (!axis_resetn)
        (ctl.pifo_in_en & ~ctl.buffer_wr_en) == '0)
        else $error("pifo_in_en set outside buffer_wr_en");

    // one insert pulse per packet
    pifo_single: assert property (@(posedge axis_aclk) disable iff (!axis_resetn)
        (|ctl.pifo_in_en) |=> (ctl.pifo_in_en == '0))
        else $error("pifo_in_en high two cycles in a row");

    cpu_resp_follows: assert property (@(posedge axis_aclk) disable iff (!axis_resetn)
        cpu_resp.valid == $past(cpu_req.valid))
        else $error("cpu_resp valid does not follow cpu_req valid");

    // second idle cycle in a row, nothing left enabled
    idle_quiet: assert property (@(posedge axis_aclk) disable iff (!axis_resetn)
        (!s_axis_tready && $past(!s_axis_tready)) |-> (ctl == '0))
        else $error("ctl active while idle");

endmodule

/* enqueue_agent_tb.sv */
`timescale 1ns/1ps

module enqueue_agent_tb;

    import enq_cfg_pkg::*;
    import sume_meta_pkg::*;

    localparam logic [31:0] SEED  = 32'h79318829;
    localparam int          SLACK = 20;

    logic                 axis_aclk = 1'b0;
    logic                 axis_resetn;
    logic                 s_axis_tvalid;
    logic                 s_axis_tready;
    sume_meta_t           s_axis_tuser;
    logic                 s_axis_tlast;
    logic                 s_axis_tpifo_valid;
    queue_status_t        queue_status;
    enq_ctl_t             ctl;
    cpu_req_t             cpu_req;
    cpu_resp_t            cpu_resp;

    // expected drops, [src][dst]
    logic [CNT_WIDTH-1:0] exp_cnt [QUEUE_NUM][QUEUE_NUM];
    int                   err_count = 0;
    int                   mark      = 0;
    int                   tests_run = 0;
    int                   tests_bad = 0;

    enqueue_agent dut (.*);

    bind enqueue_agent enqueue_agent_asserts u_asserts
    (
        .axis_aclk     (axis_aclk),
        .axis_resetn   (axis_resetn),
        .s_axis_tready (s_axis_tready),
        .ctl           (ctl),
        .cpu_req       (cpu_req),
        .cpu_resp      (cpu_resp)
    );

    always #4 axis_aclk = ~axis_aclk;

    // inputs change just after the rising edge
    task automatic step();
        @(posedge axis_aclk);
        #1;
    endtask

    ////////////////////////////////////////////////////////////
    // compare tasks
    ////////////////////////////////////////////////////////////

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp)
        begin
            $display("FAILED %s got %h expected %h at %0t", name, got, exp, $time);
            err_count++;
        end
    endtask

    task automatic check_vec(input string name, input port_vec_t got, input port_vec_t exp);
        if (got !== exp)
        begin
            $display("FAILED %s got %h expected %h at %0t", name, got, exp, $time);
            err_count++;
        end
    endtask

    task automatic check_ctl(input enq_ctl_t got, input enq_ctl_t exp);
        check_vec("ctl.pifo_in_en", got.pifo_in_en, exp.pifo_in_en);
        check_vec("ctl.buffer_wr_en", got.buffer_wr_en, exp.buffer_wr_en);
    endtask

    task automatic check_resp(input cpu_resp_t got, input cpu_resp_t exp);
        if (got !== exp)
        begin
            $display("FAILED cpu_resp got data %h valid %h expected data %h valid %h",
                     got.data, got.valid, exp.data, exp.valid);
            err_count++;
        end
    endtask

    ////////////////////////////////////////////////////////////
    // reference model
    ////////////////////////////////////////////////////////////

    // even bits are NF0..NF3, any odd bit means the CPU queue
    function automatic port_vec_t fold_dst(input logic [7:0] dst);
        port_vec_t v;
        v = '0;
        for (int b = 0; b < 8; b++)
            if (dst[b])
                v[(b % 2 == 1) ? QUEUE_NUM - 1 : b / 2] = 1'b1;
        return v;
    endfunction

    function automatic int src_index(input logic [7:0] src);
        for (int i = 0; i < 4; i++)
            if (src == 8'(1 << (2 * i)))
                return i;
        return QUEUE_NUM - 1;
    endfunction

    task automatic send_packet(input logic [7:0] src, input logic [7:0] dst, input logic drop,
                               input logic pifo_valid, input queue_status_t status,
                               input int nbeats, input int gaps, input bit back_to_back);
        port_vec_t dvec;
        port_vec_t elig;
        logic      rejected;
        enq_ctl_t  exp_ctl;
        int        beat;
        int        cyc;
        int        gaps_left;
        dvec     = fold_dst(dst);
        elig     = dvec & ~status.buffer_almost_full & ~status.pifo_full;
        rejected = drop || (elig == '0) || !pifo_valid;
        if (rejected)
            for (int d = 0; d < QUEUE_NUM; d++)
                if (dvec[d])
                    exp_cnt[src_index(src)][d] += 1;
        // decision cycle, tready still low
        s_axis_tuser          = '0;
        s_axis_tuser.src_port = src;
        s_axis_tuser.dst_port = dst;
        s_axis_tuser.drop[0]  = drop;
        s_axis_tuser.pkt_len  = 16'(nbeats * 32);
        s_axis_tpifo_valid    = pifo_valid;
        queue_status          = status;
        s_axis_tvalid         = 1'b1;
        s_axis_tlast          = (nbeats == 1);
        step();
        beat      = 0;
        cyc       = 0;
        gaps_left = gaps;
        while (beat < nbeats && cyc < nbeats + gaps + SLACK)
        begin
            // insert pulse only in the first cycle after the decision
            exp_ctl.pifo_in_en   = (rejected || cyc > 0) ? '0 : elig;
            exp_ctl.buffer_wr_en = rejected ? '0 : elig;
            check_ctl(ctl, exp_ctl);
            check_bit("s_axis_tready", s_axis_tready, 1'b1);
            s_axis_tvalid = !(beat == 1 && gaps_left > 0);
            if (!s_axis_tvalid)
                gaps_left--;
            s_axis_tlast = (beat == nbeats - 1);
            if (s_axis_tvalid && s_axis_tready)
                beat++;
            step();
            cyc++;
        end
        if (beat < nbeats)
        begin
            $display("timeout: only %0d of %0d beats taken in %0d cycles", beat, nbeats, cyc);
            err_count++;
        end
        // write enable still up in the cycle after the tlast beat
        exp_ctl.pifo_in_en   = '0;
        exp_ctl.buffer_wr_en = rejected ? '0 : elig;
        check_ctl(ctl, exp_ctl);
        check_bit("s_axis_tready", s_axis_tready, 1'b0);
        if (!back_to_back)
        begin
            s_axis_tvalid = 1'b0;
            s_axis_tlast  = 1'b0;
            step();
            check_ctl(ctl, '0);
        end
    endtask

    task automatic read_counter(input logic [3:0] src_nib, input logic [3:0] dst_nib);
        cpu_resp_t exp;
        exp.valid = 1'b1;
        exp.data  = '0;
        // bad source reads zero, bad destination folds onto the cpu column
        if (src_nib < 4'd5)
            exp.data = exp_cnt[int'(src_nib)][(dst_nib > 4'd4) ? 4 : int'(dst_nib)];
        cpu_req.addr  = {src_nib, dst_nib};
        cpu_req.valid = 1'b1;
        step();
        cpu_req.valid = 1'b0;
        check_resp(cpu_resp, exp);
    endtask

    task automatic read_matrix();
        for (int s = 0; s < QUEUE_NUM; s++)
            for (int d = 0; d < QUEUE_NUM; d++)
                read_counter(4'(s), 4'(d));
    endtask

    task automatic finish_test(input string name);
        tests_run++;
        if (err_count == mark)
            $display("test %s: ok", name);
        else
        begin
            $display("test %s: %0d errors", name, err_count - mark);
            tests_bad++;
        end
        mark = err_count;
    endtask

    ////////////////////////////////////////////////////////////
    // directed tests
    ////////////////////////////////////////////////////////////

    task automatic test_reset();
        check_bit("s_axis_tready", s_axis_tready, 1'b0);
        check_ctl(ctl, '0);
        check_resp(cpu_resp, '0);
        read_matrix();
        finish_test("reset state");
    endtask

    task automatic test_unicast();
        // NF0 to NF2 with idle beats inside the packet
        send_packet(SRC_NF0, 8'h10, 1'b0, 1'b1, '0, 3 + int'($urandom % 4), 3, 1'b0);
        finish_test("unicast enqueue");
    endtask

    task automatic test_multicast();
        queue_status_t st;
        st.buffer_almost_full = 5'b00010;
        st.pifo_full          = 5'b00001;
        send_packet(SRC_NF1, 8'h07, 1'b0, 1'b1, st, 2, 0, 1'b0);
        st.buffer_almost_full = 5'b00100;
        st.pifo_full          = 5'b01000;
        send_packet(SRC_NF3, 8'hD5, 1'b0, 1'b1, st, 4, 1, 1'b0);
        finish_test("multicast masking");
    endtask

    task automatic test_drops();
        queue_status_t st;
        st = '0;
        send_packet(SRC_NF1, 8'h14, 1'b1, 1'b1, st, 3, 0, 1'b0);
        // all destinations full, unknown source code
        st.buffer_almost_full = 5'b01000;
        st.pifo_full          = 5'b00001;
        send_packet(8'h80, 8'h41, 1'b0, 1'b1, st, 2, 1, 1'b0);
        send_packet(SRC_NF3, 8'h20, 1'b0, 1'b0, '0, 1, 0, 1'b0);
        finish_test("drops");
    endtask

    task automatic test_readback();
        read_matrix();
        read_counter(4'h3, 4'h7);
        read_counter(4'h9, 4'h2);
        repeat (6)
            read_counter(4'($urandom), 4'($urandom));
        finish_test("counter readback");
    endtask

    task automatic test_back_to_back();
        queue_status_t st;
        logic [7:0]    src;
        for (int i = 0; i < 16; i++)
        begin
            // mostly NF codes, sometimes any byte
            src = ($urandom % 3 == 0) ? 8'($urandom) : 8'(1 << (2 * ($urandom % 4)));
            st.buffer_almost_full = port_vec_t'($urandom & $urandom);
            st.pifo_full          = port_vec_t'($urandom & $urandom);
            send_packet(src, 8'($urandom % 255 + 1), ($urandom % 4) == 0, ($urandom % 8) != 0,
                        st, 1 + int'($urandom % 5), int'($urandom % 3), i < 15);
        end
        read_matrix();
        finish_test("back to back");
    endtask

    initial
    begin
        void'($urandom(SEED));
        for (int s = 0; s < QUEUE_NUM; s++)
            for (int d = 0; d < QUEUE_NUM; d++)
                exp_cnt[s][d] = '0;
        axis_resetn        = 1'b0;
        s_axis_tvalid      = 1'b0;
        s_axis_tuser       = '0;
        s_axis_tlast       = 1'b0;
        s_axis_tpifo_valid = 1'b0;
        queue_status       = '0;
        cpu_req            = '0;
        repeat (10) @(posedge axis_aclk);
        #1;
        axis_resetn = 1'b1;
        step();
        test_reset();
        test_unicast();
        test_multicast();
        test_drops();
        test_readback();
        test_back_to_back();
        $display("%0d tests run, %0d with errors, %0d errors in total",
                 tests_run, tests_bad, err_count);
        if (err_count == 0)
            $display("TESTS PASSED");
        else
            $display("TESTS FAILED");
        $finish;
    end

    initial
    begin
        #200000;
        $display("simulation did not finish within 200 us");
        $display("TESTS FAILED");
        $finish;
    end

endmodule

/* enqueue_fsm.sv */
`timescale 1ns/1ps

module enqueue_fsm
(
    input  logic                      axis_aclk,
    input  logic                      axis_resetn,
    input  logic                      tvalid,
    input  logic                      tlast,
    output logic                      tready,
    input  enq_cfg_pkg::port_vec_t    dst_vec,
    input  enq_cfg_pkg::port_vec_t    eligible_vec,
    input  enq_cfg_pkg::port_idx_t    src_idx,
    input  logic                      reject,
    output enq_cfg_pkg::enq_ctl_t     ctl,
    output enq_cfg_pkg::drop_event_t  drop_ev
);

    import enq_cfg_pkg::*;

    typedef enum logic [1:0] {
        IDLE,
        ENQUEUE,
        DROP
    } state_t;

    state_t      state;
    state_t      state_nxt;
    enq_ctl_t    ctl_nxt;
    drop_event_t drop_nxt;
    logic        last_beat;

    // first beat is judged while tready is low, so it is taken later
    assign tready = (state != IDLE);

    assign last_beat = tvalid & tready & tlast;

    ////////////////////////////////////////////////////////////
    // next state and control
    ////////////////////////////////////////////////////////////

    always_comb
    begin
        state_nxt = state;
        ctl_nxt   = ctl;
        drop_nxt  = '0;

        case (state)
            IDLE:
            begin
                // also ends the write enable one cycle after the last beat
                ctl_nxt = '0;
                if (tvalid)
                begin
                    if (reject)
                    begin
                        state_nxt        = DROP;
                        drop_nxt.valid   = 1'b1;
                        drop_nxt.src_idx = src_idx;
                        drop_nxt.dst_vec = dst_vec;
                    end
                    else
                    begin
                        state_nxt            = ENQUEUE;
                        ctl_nxt.pifo_in_en   = eligible_vec;
                        ctl_nxt.buffer_wr_en = eligible_vec;
                    end
                end
            end

            ENQUEUE:
            begin
                // pifo insert is a single pulse
                ctl_nxt.pifo_in_en = '0;
                if (last_beat)
                begin
                    state_nxt = IDLE;
                end
            end

            DROP:
            begin
                // swallow beats until the end of packet
                if (last_beat)
                begin
                    state_nxt = IDLE;
                end
            end

            default:
            begin
                state_nxt = IDLE;
                ctl_nxt   = '0;
            end
        endcase
    end

    ////////////////////////////////////////////////////////////
    // state and output registers
    ////////////////////////////////////////////////////////////

    always_ff @(posedge axis_aclk)
    begin
        if (!axis_resetn)
        begin
            state   <= IDLE;
            ctl     <= '0;
            drop_ev <= '0;
        end
        else
        begin
            state   <= state_nxt;
            ctl     <= ctl_nxt;
            drop_ev <= drop_nxt;
        end
    end

endmodule

/* meta_decoder.sv */
`timescale 1ns/1ps

module meta_decoder
(
    input  sume_meta_pkg::sume_meta_t   meta,
    input  logic                        pifo_valid,
    input  enq_cfg_pkg::queue_status_t  status,
    output enq_cfg_pkg::port_vec_t      dst_vec,
    output enq_cfg_pkg::port_idx_t      src_idx,
    output enq_cfg_pkg::port_vec_t      eligible_vec,
    output logic                        reject
);

    import enq_cfg_pkg::*;
    import sume_meta_pkg::*;

    // fold the destination byte into one bit per queue
    always_comb
    begin
        for (int i = 0; i < QUEUE_NUM - 1; i++)
        begin
            dst_vec[i] = meta.dst_port[2*i];
        end
        // any DMA bit targets the CPU queue
        dst_vec[QUEUE_NUM-1] = |(meta.dst_port & PORT_DMA_MASK);
    end

    // one-hot source to queue index, unknown codes count as CPU
    always_comb
    begin
        case (meta.src_port)
            SRC_NF0:
                src_idx = port_idx_t'(0);
            SRC_NF1:
                src_idx = port_idx_t'(1);
            SRC_NF2:
                src_idx = port_idx_t'(2);
            SRC_NF3:
                src_idx = port_idx_t'(3);
            default:
                src_idx = port_idx_t'(QUEUE_NUM - 1);
        endcase
    end

    // queues that can take the packet right now
    assign eligible_vec = dst_vec & ~status.buffer_almost_full & ~status.pifo_full;

    // drop flag, nowhere to go, or no valid pifo info
    assign reject = meta.drop[0] | ~(|eligible_vec) | ~pifo_valid;

endmodule

/* run_sim.sh */
#!/bin/sh
# build and run the enqueue agent testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
    --top-module enqueue_agent_tb -f enqueue_agent.f \
    -Mdir obj_dir -o enqueue_agent_sim
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/enqueue_agent_sim > sim.log 2>&1
run_status=$?
cat sim.log
if [ $run_status -ne 0 ]; then
    echo "simulation exited with status $run_status"
    exit 1
fi

if grep -q "TESTS PASSED" sim.log; then
    exit 0
fi
echo "pass message not found in sim.log"
exit 1

/* sume_meta_pkg.sv */
package sume_meta_pkg;

    ////////////////////////////////////////////////////////////
    // pipeline metadata word, msb first
    ////////////////////////////////////////////////////////////

    typedef struct packed {
        logic [79:0] digest_data;
        logic [7:0]  send_dig_to_cpu;
        // only bit 0 is meaningful
        logic [7:0]  drop;
        logic [7:0]  dst_port;
        logic [7:0]  src_port;
        logic [15:0] pkt_len;
    } sume_meta_t;

    ////////////////////////////////////////////////////////////
    // port byte codes
    ////////////////////////////////////////////////////////////

    // even bits are the NF ports
    localparam logic [7:0] SRC_NF0 = 8'h01;
    localparam logic [7:0] SRC_NF1 = 8'h04;
    localparam logic [7:0] SRC_NF2 = 8'h10;
    localparam logic [7:0] SRC_NF3 = 8'h40;

    // odd bits all point at DMA
    localparam logic [7:0] PORT_DMA_MASK = 8'hAA;

endpackage
